/* dv/udp_rx_cases.txt */
// Columns: destination MAC (48 bits) _ payload length (16 bits) _ stall _ abort, in hex.
// One frame per line, sent in file order; the local MAC is 020000000001.
020000000001_000a_0_0
0a1b2c3d4e5f_0014_0_0
020000000001_0010_0_0
020000000001_0040_1_0
020000000001_0100_1_0
020000000001_0020_0_1
020000000001_0019_0_0
020000000003_0030_1_0
020000000001_0001_0_0
020000000001_0012_0_0
020000000001_012c_0_0
020000000001_012c_1_0
0200000000ff_0020_0_1
020000000001_0007_1_0
020000000001_0003_0_0
020000000001_0021_1_0

/* flist.f */
source/rgmii_pkg.sv
source/gmii_rx_sampler.sv
source/packet_recv.sv
source/stream_fifo.sv
source/udp_rx_top.sv
dv/udp_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module udp_rx_tb \
    -o udp_rx_sim

status=0
output=$(./obj_dir/udp_rx_sim 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -q "^STATUS: PASS$"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

/* dv/udp_rx_tb.sv */
`timescale 1ns/1ns

module udp_rx_tb;

    localparam int          MAX_CASES  = 32;
    localparam int          WAIT_LIMIT = 4000;
    localparam logic [47:0] LOCAL_MAC  = 48'h02_00_00_00_00_01;
    localparam logic [47:0] SOURCE_MAC = 48'h02_00_00_00_00_99;

    logic        clk_i;
    logic        rst_i;
    logic [7:0]  rx_d_i;
    logic        rx_dv_i;
    logic [47:0] local_mac_i;
    logic        m_valid_o;
    logic        m_ready_i;
    logic [7:0]  m_data_o;
    logic        m_last_o;

    // Each word holds the destination MAC, payload length, stall and abort nibbles.
    logic [71:0] case_words [MAX_CASES];
    logic [7:0]  frame_q [$];
    logic [8:0]  expect_q [$];
    integer      seed;
    logic        stall_mode;
    int          error_count;
    int          got_count;
    int          exp_count;
    int          pass_count;
    int          fail_count;

    udp_rx_top udp_rx_top_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rx_d_i     (rx_d_i),
        .rx_dv_i    (rx_dv_i),
        .local_mac_i(local_mac_i),
        .m_valid_o  (m_valid_o),
        .m_ready_i  (m_ready_i),
        .m_data_o   (m_data_o),
        .m_last_o   (m_last_o)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #20 clk_i = ~clk_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stream checker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk_i) begin
        if (!rst_i && m_valid_o && m_ready_i) begin
            got_count <= got_count + 1;
            if (expect_q.size() == 0) begin
                $display("FAILED at %0t ns: unexpected beat data %h last %b",
                         $time, m_data_o, m_last_o);
                error_count = error_count + 1;
            end else begin
                if ({m_last_o, m_data_o} !== expect_q[0]) begin
                    $display("FAILED at %0t ns: got data %h last %b, expected data %h last %b",
                             $time, m_data_o, m_last_o, expect_q[0][7:0], expect_q[0][8]);
                    error_count = error_count + 1;
                end
                void'(expect_q.pop_front());
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic step_cycle(input logic [7:0] data, input logic valid);
        @(posedge clk_i);
        rx_d_i  <= data;
        rx_dv_i <= valid;
        if (stall_mode) begin
            m_ready_i <= 1'($random(seed));
        end else begin
            m_ready_i <= 1'b1;
        end
    endtask

    // Network order, so the most significant byte goes out first.
    task automatic push_bytes(input logic [47:0] value, input int count);
        int n;
        for (n = count - 1; n >= 0; n--) begin
            frame_q.push_back(value[n*8 +: 8]);
        end
    endtask

    task automatic build_frame(input logic [47:0] dst, input int len, input logic abort);
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        logic [7:0]  pay;
        logic        deliver;
        int          i;
        frame_q.delete();
        ip_len  = 16'(len + 28);
        udp_len = 16'(len + 8);
        deliver = (dst == LOCAL_MAC) && !abort;
        repeat (7) frame_q.push_back(8'h55);
        frame_q.push_back(8'hd5);
        push_bytes(dst, 6);
        push_bytes(SOURCE_MAC, 6);
        push_bytes(48'h0800, 2);
        push_bytes(48'h4500, 2);
        push_bytes({32'h0, ip_len}, 2);
        push_bytes(48'h0000_4000, 4);
        push_bytes(48'h4011, 2);
        push_bytes(48'h0000, 2);
        push_bytes(48'hc0a8_0102, 4);
        push_bytes(48'hc0a8_0101, 4);
        push_bytes(48'h04d2_162e, 4);
        push_bytes({32'h0, udp_len}, 2);
        push_bytes(48'h0000, 2);
        if (abort) begin
            // The data-valid level drops after the 20th header byte.
            while (frame_q.size() > 28) begin
                void'(frame_q.pop_back());
            end
        end else begin
            for (i = 0; i < len; i++) begin
                pay = 8'($random(seed));
                frame_q.push_back(pay);
                if (deliver) begin
                    expect_q.push_back({i == len - 1, pay});
                    exp_count++;
                end
            end
            push_bytes(48'hdead_beef, 4);
        end
    endtask

    task automatic finish_case(input int idx, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("case %0d passed", idx);
        end else begin
            fail_count++;
            $display("case %0d failed with %0d errors", idx, error_count - errs_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int   k;
        int   i;
        int   errs_before;
        int   waited;
        logic timed_out;
        rst_i       = 1'b1;
        rx_d_i      = 8'h00;
        rx_dv_i     = 1'b0;
        m_ready_i   = 1'b0;
        local_mac_i = LOCAL_MAC;
        stall_mode  = 1'b0;
        seed        = 32'hb3da_98af;
        error_count = 0;
        got_count   = 0;
        exp_count   = 0;
        pass_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;
        for (k = 0; k < MAX_CASES; k++) begin
            case_words[k] = '1;
        end
        $readmemh("dv/udp_rx_cases.txt", case_words);

        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        // Case 0 is the quiet interval right after reset.
        errs_before = error_count;
        for (i = 0; i < 20; i++) begin
            step_cycle(8'h00, 1'b0);
            if (m_valid_o !== 1'b0) begin
                $display("FAILED at %0t ns: m_valid_o is %b before any frame", $time, m_valid_o);
                error_count++;
            end
        end
        finish_case(0, errs_before);

        k = 0;
        while (k < MAX_CASES && case_words[k] !== '1 && !timed_out) begin
            errs_before = error_count;
            build_frame(case_words[k][71:24], int'(case_words[k][23:8]),
                        case_words[k][3:0] != 4'h0);
            stall_mode = (case_words[k][7:4] != 4'h0);
            for (i = 0; i < frame_q.size(); i++) begin
                step_cycle(frame_q[i], 1'b1);
            end
            repeat (12) step_cycle(8'h00, 1'b0);
            waited = 0;
            while (got_count < exp_count && waited < WAIT_LIMIT) begin
                step_cycle(8'h00, 1'b0);
                waited++;
            end
            if (got_count < exp_count) begin
                $display("case %0d: timeout, the output stream stalled after %0d of %0d beats",
                         k + 1, got_count, exp_count);
                error_count++;
                timed_out = 1'b1;
            end
            stall_mode = 1'b0;
            finish_case(k + 1, errs_before);
            k++;
        end

        // A stray beat after the final frame still reaches the checker here.
        repeat (12) step_cycle(8'h00, 1'b0);

        $display("cases passed: %0d, cases failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* source/udp_rx_top.sv */
`timescale 1ns/1ns

module udp_rx_top #(
    parameter int FIFO_ADDR_WIDTH = 11
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  rgmii_pkg::byte_t     rx_d_i,
    input  logic                 rx_dv_i,
    input  rgmii_pkg::mac_addr_t local_mac_i,
    output logic                 m_valid_o,
    input  logic                 m_ready_i,
    output rgmii_pkg::byte_t     m_data_o,
    output logic                 m_last_o
);

    import rgmii_pkg::*;

    gmii_beat_t   rx_beat;
    logic         wr_valid;
    stream_beat_t wr_beat;
    stream_beat_t m_beat;

    gmii_rx_sampler gmii_rx_sampler_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .rx_d_i (rx_d_i),
        .rx_dv_i(rx_dv_i),
        .beat_o (rx_beat)
    );

    packet_recv packet_recv_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .beat_i     (rx_beat),
        .local_mac_i(local_mac_i),
        .wr_valid_o (wr_valid),
        .wr_beat_o  (wr_beat)
    );

    stream_fifo #(
        .ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) stream_fifo_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_valid_i(wr_valid),
        .wr_beat_i (wr_beat),
        .m_valid_o (m_valid_o),
        .m_ready_i (m_ready_i),
        .m_beat_o  (m_beat)
    );

    assign m_data_o = m_beat.data;
    assign m_last_o = m_beat.last;

endmodule

/* source/stream_fifo.sv */
`timescale 1ns/1ns

module stream_fifo #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    wr_valid_i,
    input  rgmii_pkg::stream_beat_t wr_beat_i,
    output logic                    m_valid_o,
    input  logic                    m_ready_i,
    output rgmii_pkg::stream_beat_t m_beat_o
);

    import rgmii_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    stream_beat_t        mem [DEPTH];
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic                mem_empty;
    logic                full;
    logic                load_out;
    logic                mem_re;
    logic                mem_we;
    logic                bypass;

    // The extra pointer bit tells a full buffer from an empty one.
    assign mem_empty = (wr_ptr == rd_ptr);
    assign full      = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                       (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    // The output register takes a new beat when it is empty or being drained.
    assign load_out = !m_valid_o || m_ready_i;
    assign mem_re   = load_out && !mem_empty;

    // With nothing queued, an incoming beat goes straight to the output stage.
    assign bypass = load_out && mem_empty && wr_valid_i;
    assign mem_we = wr_valid_i && !full && !bypass;

    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_beat_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            m_valid_o <= 1'b0;
        end else begin
            if (mem_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_re) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (load_out) begin
                m_valid_o <= mem_re || bypass;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_re) begin
            m_beat_o <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end else if (bypass) begin
            m_beat_o <= wr_beat_i;
        end
    end

    // The parser cannot wait, so the depth must absorb any stall on the reader.
    a_no_write_when_full : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(wr_valid_i && full)
    );

    a_hold_under_backpressure : assert property (
        @(posedge clk_i) disable iff (rst_i)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o)
    );

endmodule

/* source/packet_recv.sv */
`timescale 1ns/1ns

module packet_recv (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  rgmii_pkg::gmii_beat_t   beat_i,
    input  rgmii_pkg::mac_addr_t    local_mac_i,
    output logic                    wr_valid_o,
    output rgmii_pkg::stream_beat_t wr_beat_o
);

    import rgmii_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE_SFD,
        HEADER,
        PAYLOAD,
        FCS
    } parse_state_t;

    localparam logic [63:0] DELIMITER = {{7{PREAMBLE_BYTE}}, SFD_BYTE};

    parse_state_t  state;
    parse_state_t  next_state;
    len16_t        byte_cnt;
    logic [63:0]   window;
    logic [63:0]   window_next;
    frame_header_t header;
    len16_t        payload_len;
    logic          last_payload;
    logic          mac_match;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Header decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Newest byte enters at the bottom, so the SFD ends up in the low byte.
    assign window_next = {window[55:0], beat_i.data};

    // The header is complete by the time the machine reaches PAYLOAD.
    assign payload_len  = header.ip_total_length - len16_t'(IP_UDP_OVERHEAD);
    assign last_payload = (byte_cnt == payload_len - len16_t'(1));
    assign mac_match    = (header.dst_mac == local_mac_i);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (beat_i.start) begin
                    next_state = PREAMBLE_SFD;
                end
            end
            PREAMBLE_SFD: begin
                if (beat_i.done) begin
                    next_state = IDLE;
                end else if (window_next == DELIMITER) begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                if (beat_i.done) begin
                    next_state = IDLE;
                end else if (byte_cnt == len16_t'(HEADER_BYTES - 1)) begin
                    next_state = PAYLOAD;
                end
            end
            PAYLOAD: begin
                if (last_payload) begin
                    next_state = FCS;
                end
            end
            FCS: begin
                if (byte_cnt == len16_t'(FCS_BYTES - 1)) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state    <= IDLE;
            byte_cnt <= '0;
            window   <= '0;
        end else begin
            state <= next_state;

            // Counts bytes within a state and restarts on every transition.
            if (state != next_state || state == IDLE) begin
                byte_cnt <= '0;
            end else begin
                byte_cnt <= byte_cnt + len16_t'(1);
            end

            if (state == PREAMBLE_SFD) begin
                window <= window_next;
            end else begin
                window <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == HEADER) begin
            header <= {header[$bits(frame_header_t)-9:0], beat_i.data};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Payload write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_valid_o <= 1'b0;
        end else begin
            wr_valid_o <= (state == PAYLOAD) && mac_match;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == PAYLOAD) begin
            wr_beat_o.data <= beat_i.data;
            wr_beat_o.last <= last_payload;
        end
    end

    // The write that closes the payload coincides with the move to FCS.
    a_last_ends_payload : assert property (
        @(posedge clk_i) disable iff (rst_i)
        wr_valid_o |-> (wr_beat_o.last ? state == FCS : state == PAYLOAD)
    );

endmodule

/* source/gmii_rx_sampler.sv */
`timescale 1ns/1ns

module gmii_rx_sampler (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  rgmii_pkg::byte_t      rx_d_i,
    input  logic                  rx_dv_i,
    output rgmii_pkg::gmii_beat_t beat_o
);

    import rgmii_pkg::*;

    byte_t [2:0] data_z;
    logic  [2:0] dv_z;

    always_ff @(posedge clk_i) begin
        data_z <= {data_z[1:0], rx_d_i};
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dv_z <= '0;
        end else begin
            dv_z <= {dv_z[1:0], rx_dv_i};
        end
    end

    // The edges come from the last two valid stages. A start pulse is seen
    // one cycle before the first frame byte reaches the data field, so the
    // parser is already out of IDLE when that byte arrives.
    assign beat_o.data  = data_z[2];
    assign beat_o.start = dv_z[1] & ~dv_z[2];
    assign beat_o.done  = dv_z[2] & ~dv_z[1];

    // The byte that follows a start pulse opens the preamble.
    a_start_aligned : assert property (
        @(posedge clk_i) disable iff (rst_i)
        beat_o.start |=> beat_o.data == PREAMBLE_BYTE
    );

endmodule

/* source/rgmii_pkg.sv */
package rgmii_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] len16_t;
    typedef logic [31:0] ipv4_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    // Ethernet (14) + IPv4 (20) + UDP (8) bytes between the SFD and the payload.
    localparam int HEADER_BYTES    = 42;
    localparam int IP_UDP_OVERHEAD = 28;
    localparam int FCS_BYTES       = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Beats between blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        byte_t data;
        logic  start;
        logic  done;
    } gmii_beat_t;

    typedef struct packed {
        byte_t data;
        logic  last;
    } stream_beat_t;

    // The first byte on the wire lands in the most significant field.
    typedef struct packed {
        mac_addr_t  dst_mac;
        mac_addr_t  src_mac;
        len16_t     ethertype;
        byte_t      ip_ver_ihl;
        byte_t      ip_tos;
        len16_t     ip_total_length;
        len16_t     ip_ident;
        len16_t     ip_flags_frag;
        byte_t      ip_ttl;
        byte_t      ip_protocol;
        len16_t     ip_checksum;
        ipv4_addr_t ip_src;
        ipv4_addr_t ip_dst;
        len16_t     udp_src_port;
        len16_t     udp_dst_port;
        len16_t     udp_length;
        len16_t     udp_checksum;
    } frame_header_t;

endpackage
